// ==== logic/lsu_mem_ctrl.sv ====
`timescale 1ns/100ps

`include "mem_settings.svh"

module lsu_mem_ctrl import mem_pkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       rd_en,
    input  logic       wr_en,
    input  func3_t     func3,
    input  addr_t      addr,
    input  data_t      wdata,
    output logic       ready,
    output data_t      rdata,
    output logic       req,
    output logic       we,
    output word_addr_t waddr,
    output data_t      wdat,
    input  logic       ack,
    input  data_t      rdat
);

    lsu_state_t state;
    mem_op_t    op_dec;
    mem_op_t    op_r;
    logic [1:0] off_r;
    data_t      rd_word;
    data_t      load_val;
    data_t      merged;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;
    logic       accept;
    logic       is_sub_store;

    assign ready        = (state == IDLE);
    assign accept       = ready && (rd_en || wr_en);
    assign is_sub_store = (op_r == SB) || (op_r == SH);

    // Read wins when both enables are high
    always_comb begin
        op_dec = NOP;
        if (rd_en) begin
            case (func3)
                3'b000:  op_dec = LB;
                3'b001:  op_dec = LH;
                3'b010:  op_dec = LW;
                3'b100:  op_dec = LBU;
                3'b101:  op_dec = LHU;
                default: op_dec = NOP;
            endcase
        end else if (wr_en) begin
            case (func3)
                3'b000:  op_dec = SB;
                3'b001:  op_dec = SH;
                3'b010:  op_dec = SW;
                default: op_dec = NOP;
            endcase
        end
    end

    // Lane pick from the word read back
    assign byte_sel = rd_word[8*off_r +: 8];
    assign half_sel = rd_word[16*off_r[1] +: 16];

    always_comb begin
        case (op_r)
            LB:      load_val = {{(`DATA_WIDTH-8){byte_sel[7]}}, byte_sel};
            LH:      load_val = {{(`DATA_WIDTH-16){half_sel[15]}}, half_sel};
            LBU:     load_val = {{(`DATA_WIDTH-8){1'b0}}, byte_sel};
            LHU:     load_val = {{(`DATA_WIDTH-16){1'b0}}, half_sel};
            default: load_val = rd_word;
        endcase
    end

    // Store data goes into the lane named by the low address bits
    always_comb begin
        merged = rd_word;
        if (op_r == SB) begin
            merged[8*off_r +: 8] = wdat[7:0];
        end else begin
            merged[16*off_r[1] +: 16] = wdat[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            req   <= 1'b0;
            we    <= 1'b0;
            rdata <= '0;
        end else begin
            case (state)
                IDLE: begin
                    // NOP completes on the spot with ready left high
                    if (accept && (op_dec != NOP)) begin
                        req <= 1'b1;
                        we  <= (op_dec == SW);
                        state <= (op_dec == SW) ? WR_REQ : RD_REQ;
                    end
                end
                RD_REQ: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= RD_DONE;
                    end
                end
                RD_DONE: begin
                    if (!ack) begin
                        if (is_sub_store) begin
                            req   <= 1'b1;
                            we    <= 1'b1;
                            state <= WR_REQ;
                        end else begin
                            rdata <= load_val;
                            state <= IDLE;
                        end
                    end
                end
                WR_REQ: begin
                    if (ack) begin
                        req   <= 1'b0;
                        state <= WR_DONE;
                    end
                end
                WR_DONE: begin
                    if (!ack) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Request fields, only touched while req is low
    always_ff @(posedge clk) begin
        if (accept) begin
            op_r  <= op_dec;
            waddr <= addr[`WORD_ADDR_WIDTH+1:2];
            off_r <= addr[1:0];
            wdat  <= wdata;
        end else if (state == RD_REQ && ack) begin
            rd_word <= rdat;
        end else if (state == RD_DONE && !ack && is_sub_store) begin
            wdat <= merged;
        end
    end

    // Four-phase: a new request only once the previous ack is gone
    req_after_ack_low: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(req) |-> !ack && !$past(ack)
    ) else $error("lsu_mem_ctrl: req raised while ack still high");

endmodule : lsu_mem_ctrl

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/100ps

`include "mem_settings.svh"

module mem_arbiter import mem_pkg::*; (
    input  logic       clk,
    input  logic       rstN,

    input  logic       req_0,
    input  logic       we_0,
    input  word_addr_t waddr_0,
    input  data_t      wdat_0,
    output logic       ack_0,
    output data_t      rdat_0,

    input  logic       req_1,
    input  logic       we_1,
    input  word_addr_t waddr_1,
    input  data_t      wdat_1,
    output logic       ack_1,
    output data_t      rdat_1,

    output logic       ram_req,
    output logic       ram_we,
    output word_addr_t ram_addr,
    output data_t      ram_wdata,
    input  logic       ram_ack,
    input  data_t      ram_rdata
);

    logic granted;
    // Owner doubles as the last-granted bit for round robin
    logic owner;
    logic owner_req;
    logic pick;

    assign owner_req = owner ? req_1 : req_0;

    // Contention goes to whoever was not granted last
    always_comb begin
        if (req_0 && req_1) begin
            pick = !owner;
        end else begin
            pick = req_1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            granted <= 1'b0;
            owner   <= 1'b1;
        end else if (!granted) begin
            // Port is idle here since ram_req is gated by granted
            if ((req_0 || req_1) && !ram_ack) begin
                granted <= 1'b1;
                owner   <= pick;
            end
        end else if (!owner_req && !ram_ack) begin
            granted <= 1'b0;
        end
    end

    assign ram_req   = granted && owner_req;
    assign ram_we    = owner ? we_1 : we_0;
    assign ram_addr  = owner ? waddr_1 : waddr_0;
    assign ram_wdata = owner ? wdat_1 : wdat_0;

    // Only the owner sees the RAM response
    assign ack_0  = granted && !owner && ram_ack;
    assign ack_1  = granted && owner && ram_ack;
    assign rdat_0 = (granted && !owner) ? ram_rdata : '0;
    assign rdat_1 = (granted && owner) ? ram_rdata : '0;

    // An ack answers the request this client itself put on the RAM port
    ack_0_owned: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(ack_0) |-> req_0 && $past(ram_req && !owner)
    ) else $error("mem_arbiter: client 0 acked without owning the port");

    ack_1_owned: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(ack_1) |-> req_1 && $past(ram_req && owner)
    ) else $error("mem_arbiter: client 1 acked without owning the port");

    // Owner moves only while ungranted, so an ack there would reach the wrong client
    ack_within_grant: assert property (
        @(posedge clk) disable iff (!rstN)
        ram_ack |-> granted
    ) else $error("mem_arbiter: RAM ack while the port is not granted");

endmodule : mem_arbiter

// ==== logic/mem_pkg.sv ====
`include "mem_settings.svh"

package mem_pkg;

    // Byte address from the hart
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // Word index into the RAM, byte addresses wrap modulo the depth
    typedef logic [`WORD_ADDR_WIDTH-1:0] word_addr_t;

    typedef logic [`DATA_WIDTH-1:0] data_t;

    // Raw RV32 funct3 field
    typedef logic [2:0] func3_t;

    // Decoded load/store operation
    typedef enum logic [3:0] {
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        NOP
    } mem_op_t;

    // Controller FSM
    typedef enum logic [2:0] {
        IDLE,
        RD_REQ,
        RD_DONE,
        WR_REQ,
        WR_DONE
    } lsu_state_t;

endpackage : mem_pkg

// ==== logic/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Number of 32-bit words in the shared RAM
`define MEM_DEPTH_WORDS 1024

// Byte address as seen by a hart
`define ADDR_WIDTH 32

// Data word width
`define DATA_WIDTH 32

// Word index into the RAM, log2 of the depth
`define WORD_ADDR_WIDTH 10

// Cycles from the RAM seeing req to raising ack
`define MEM_ACCESS_DELAY 2

`endif

// ==== logic/shared_dmem_top.sv ====
`timescale 1ns/100ps

`include "mem_settings.svh"

module shared_dmem_top import mem_pkg::*; (
    input  logic   clk,
    input  logic   rstN,

    input  logic   rd_en_a,
    input  logic   wr_en_a,
    input  func3_t func3_a,
    input  addr_t  addr_a,
    input  data_t  wdata_a,
    output logic   ready_a,
    output data_t  rdata_a,

    input  logic   rd_en_b,
    input  logic   wr_en_b,
    input  func3_t func3_b,
    input  addr_t  addr_b,
    input  data_t  wdata_b,
    output logic   ready_b,
    output data_t  rdata_b
);

    // Controller to arbiter
    logic       req_a, we_a, ack_a;
    logic       req_b, we_b, ack_b;
    word_addr_t waddr_a, waddr_b;
    data_t      wdat_a, wdat_b;
    data_t      rdat_a, rdat_b;

    // Arbiter to RAM
    logic       ram_req, ram_we, ram_ack;
    word_addr_t ram_addr;
    data_t      ram_wdata, ram_rdata;

    lsu_mem_ctrl ctrl_a_i (
        .clk(clk), .rstN(rstN),
        .rd_en(rd_en_a), .wr_en(wr_en_a), .func3(func3_a), .addr(addr_a), .wdata(wdata_a),
        .ready(ready_a), .rdata(rdata_a),
        .req(req_a), .we(we_a), .waddr(waddr_a), .wdat(wdat_a), .ack(ack_a), .rdat(rdat_a)
    );

    lsu_mem_ctrl ctrl_b_i (
        .clk(clk), .rstN(rstN),
        .rd_en(rd_en_b), .wr_en(wr_en_b), .func3(func3_b), .addr(addr_b), .wdata(wdata_b),
        .ready(ready_b), .rdata(rdata_b),
        .req(req_b), .we(we_b), .waddr(waddr_b), .wdat(wdat_b), .ack(ack_b), .rdat(rdat_b)
    );

    mem_arbiter arb_i (
        .clk(clk), .rstN(rstN),
        .req_0(req_a), .we_0(we_a), .waddr_0(waddr_a), .wdat_0(wdat_a),
        .ack_0(ack_a), .rdat_0(rdat_a),
        .req_1(req_b), .we_1(we_b), .waddr_1(waddr_b), .wdat_1(wdat_b),
        .ack_1(ack_b), .rdat_1(rdat_b),
        .ram_req(ram_req), .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .ram_ack(ram_ack), .ram_rdata(ram_rdata)
    );

    word_ram ram_i (
        .clk(clk), .rstN(rstN),
        .req(ram_req), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata),
        .ack(ram_ack), .rdata(ram_rdata)
    );

endmodule : shared_dmem_top

// ==== logic/word_ram.sv ====
`timescale 1ns/100ps

`include "mem_settings.svh"

module word_ram import mem_pkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       req,
    input  logic       we,
    input  word_addr_t addr,
    input  data_t      wdata,
    output logic       ack,
    output data_t      rdata
);

    localparam int CNT_WIDTH = $clog2(`MEM_ACCESS_DELAY) + 1;
    localparam logic [CNT_WIDTH-1:0] LAST_CNT = CNT_WIDTH'(`MEM_ACCESS_DELAY - 1);

    data_t mem [`MEM_DEPTH_WORDS];

    logic [CNT_WIDTH-1:0] cnt;
    logic                 fire;

    // Access happens on the edge that raises ack
    assign fire = req && !ack && (cnt == LAST_CNT);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            cnt <= '0;
            ack <= 1'b0;
        end else if (ack) begin
            // Hold ack until the requester lets go
            if (!req) begin
                ack <= 1'b0;
            end
        end else if (req) begin
            if (fire) begin
                ack <= 1'b1;
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // Word array, read data held until the next read
    always_ff @(posedge clk) begin
        if (fire) begin
            if (we) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];
            end
        end
    end

    // Four-phase: a request is only withdrawn once it has been acked
    req_held_until_ack: assert property (
        @(posedge clk) disable iff (!rstN)
        $fell(req) |-> $past(ack)
    ) else $error("word_ram: req dropped before ack");

endmodule : word_ram

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps \
    --top-module tb_shared_dmem \
    -f shared_dmem.f

./obj_dir/Vtb_shared_dmem > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"

// ==== shared_dmem.f ====
+incdir+logic
logic/mem_pkg.sv
logic/word_ram.sv
logic/mem_arbiter.sv
logic/lsu_mem_ctrl.sv
logic/shared_dmem_top.sv
test/tb_shared_dmem.sv

// ==== test/tb_shared_dmem.sv ====
`timescale 1ns/100ps

`include "mem_settings.svh"

module tb_shared_dmem import mem_pkg::*; ();

    localparam int HALF_WORDS = `MEM_DEPTH_WORDS / 2;
    localparam int N_RAND = 400;
    // Fill writes, fill reads, then at most two ops per random step
    localparam int OPS_PER_HART = 2 * HALF_WORDS + 2 * N_RAND;
    localparam int CYCLES_PER_OP = 40;
    localparam longint TIMEOUT_NS = (longint'(2 * OPS_PER_HART) * CYCLES_PER_OP + 20) * 20;
    localparam int BYTE_W = `WORD_ADDR_WIDTH + 2;

    typedef logic [BYTE_W-1:0] byte_idx_t;

    logic   clk = 1'b0;
    logic   rstN;
    logic   rd_en_a, wr_en_a, ready_a;
    logic   rd_en_b, wr_en_b, ready_b;
    func3_t func3_a, func3_b;
    addr_t  addr_a, addr_b;
    data_t  wdata_a, wdata_b;
    data_t  rdata_a, rdata_b;

    // Byte-wide image of the RAM, little endian
    logic [7:0] model [4 * `MEM_DEPTH_WORDS];
    data_t      last_load [2];
    int         n_checks;
    int         n_value_err;
    int         n_other_err;

    shared_dmem_top dut_i (
        .clk(clk), .rstN(rstN),
        .rd_en_a(rd_en_a), .wr_en_a(wr_en_a), .func3_a(func3_a), .addr_a(addr_a),
        .wdata_a(wdata_a), .ready_a(ready_a), .rdata_a(rdata_a),
        .rd_en_b(rd_en_b), .wr_en_b(wr_en_b), .func3_b(func3_b), .addr_b(addr_b),
        .wdata_b(wdata_b), .ready_b(ready_b), .rdata_b(rdata_b)
    );

    always #10 clk = ~clk;

    function automatic logic is_ready(bit h);
        return h ? ready_b : ready_a;
    endfunction

    // RV32 rule for which funct3 codes exist on each side
    function automatic bit op_valid(bit rd, func3_t f3);
        if (rd) begin
            return f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
        end
        return f3 inside {3'b000, 3'b001, 3'b010};
    endfunction

    function automatic data_t load_value(func3_t f3, byte_idx_t a);
        byte_idx_t a1;
        byte_idx_t a2;
        byte_idx_t a3;
        a1 = a + 1'b1;
        a2 = a + 2'd2;
        a3 = a + 2'd3;
        case (f3)
            3'b000:  return {{24{model[a][7]}}, model[a]};
            3'b001:  return {{16{model[a1][7]}}, model[a1], model[a]};
            3'b100:  return {24'h0, model[a]};
            3'b101:  return {16'h0, model[a1], model[a]};
            default: return {model[a3], model[a2], model[a1], model[a]};
        endcase
    endfunction

    function automatic void store_model(func3_t f3, byte_idx_t a, data_t wd);
        model[a] = wd[7:0];
        if (f3 != 3'b000) begin
            model[a + 1'b1] = wd[15:8];
        end
        if (f3 == 3'b010) begin
            model[a + 2'd2] = wd[23:16];
            model[a + 2'd3] = wd[31:24];
        end
    endfunction

    // One of LB, LH, LBU, LHU
    function automatic func3_t sub_load_f3();
        return {1'($urandom_range(1)), 1'b0, 1'($urandom_range(1))};
    endfunction

    // Halves stay on a half boundary
    function automatic logic [1:0] lane_offset(func3_t f3);
        return f3[0] ? {1'($urandom_range(1)), 1'b0} : 2'($urandom_range(3));
    endfunction

    function automatic addr_t byte_addr(int unsigned w, logic [1:0] off);
        return addr_t'(w * 4 + off);
    endfunction

    task automatic check_value(string name, data_t expected, data_t got);
        n_checks++;
        assert (got == expected) else begin
            n_value_err++;
            $display("ERR %s exp %08h got %08h", name, expected, got);
        end
    endtask

    task automatic drive_port(bit h, bit rd, bit wr, func3_t f3, addr_t a, data_t wd);
        if (h) begin
            rd_en_b <= rd;
            wr_en_b <= wr;
            func3_b <= f3;
            addr_b  <= a;
            wdata_b <= wd;
        end else begin
            rd_en_a <= rd;
            wr_en_a <= wr;
            func3_a <= f3;
            addr_a  <= a;
            wdata_a <= wd;
        end
    endtask

    // Issue one op, wait for completion and check rdata against the model
    task automatic do_op(bit h, bit rd, bit wr, func3_t f3, addr_t a, data_t wd);
        data_t got;
        bit    valid;
        valid = op_valid(rd, f3);
        while (!is_ready(h)) @(negedge clk);
        @(posedge clk);
        drive_port(h, rd, wr, f3, a, wd);
        @(posedge clk);
        drive_port(h, 1'b0, 1'b0, f3, a, wd);
        @(negedge clk);
        if (!valid) begin
            n_checks++;
            assert (is_ready(h)) else begin
                n_other_err++;
                $display("Hart %0d dropped ready on an op with invalid func3", h);
            end
        end
        while (!is_ready(h)) @(negedge clk);
        if (valid && rd) begin
            last_load[h] = load_value(f3, a[BYTE_W-1:0]);
        end else if (valid) begin
            store_model(f3, a[BYTE_W-1:0], wd);
        end
        // Stores and no-ops leave rdata at the last load
        got = h ? rdata_b : rdata_a;
        check_value(h ? "rdata_b" : "rdata_a", last_load[h], got);
    endtask

    task automatic run_hart(bit h);
        int unsigned base;
        int unsigned w;
        func3_t      f3;
        base = h ? HALF_WORDS : 0;
        for (int i = 0; i < HALF_WORDS; i++) begin
            do_op(h, 1'b0, 1'b1, 3'b010, byte_addr(base + i, 2'd0), $urandom);
        end
        for (int i = 0; i < HALF_WORDS; i++) begin
            do_op(h, 1'b1, 1'b0, 3'b010, byte_addr(base + i, 2'd0), 32'h0);
        end
        for (int i = 0; i < N_RAND; i++) begin
            w = base + $urandom_range(HALF_WORDS - 1);
            case ($urandom_range(3))
                0: begin
                    f3 = sub_load_f3();
                    do_op(h, 1'b1, 1'b0, f3, byte_addr(w, lane_offset(f3)), $urandom);
                end
                1: begin
                    // Read-modify-write, then the whole word back
                    f3 = 3'($urandom_range(1));
                    do_op(h, 1'b0, 1'b1, f3, byte_addr(w, lane_offset(f3)), $urandom);
                    do_op(h, 1'b1, 1'b0, 3'b010, byte_addr(w, 2'd0), 32'h0);
                end
                2: begin
                    if ($urandom_range(3) == 0) begin
                        do_op(h, 1'b0, 1'b1, 3'b011, byte_addr(w, 2'($urandom_range(3))),
                              $urandom);
                    end else begin
                        f3 = ($urandom_range(2) == 0) ? 3'b011 : {2'b11, 1'($urandom_range(1))};
                        do_op(h, 1'b1, 1'b0, f3, byte_addr(w, 2'($urandom_range(3))), $urandom);
                    end
                    do_op(h, 1'b1, 1'b0, 3'b010, byte_addr(w, 2'd0), 32'h0);
                end
                default: begin
                    // Both enables high, so the store data must not land
                    f3 = sub_load_f3();
                    do_op(h, 1'b1, 1'b1, f3, byte_addr(w, lane_offset(f3)), $urandom);
                    do_op(h, 1'b1, 1'b0, 3'b010, byte_addr(w, 2'd0), 32'h0);
                end
            endcase
        end
    endtask

    initial begin
        void'($urandom(32'h2cadbe65));
        rstN = 1'b0;
        rd_en_a = 1'b0;
        wr_en_a = 1'b0;
        func3_a = '0;
        addr_a = '0;
        wdata_a = '0;
        rd_en_b = 1'b0;
        wr_en_b = 1'b0;
        func3_b = '0;
        addr_b = '0;
        wdata_b = '0;
        last_load[0] = '0;
        last_load[1] = '0;
        n_checks = 0;
        n_value_err = 0;
        n_other_err = 0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        check_value("ready_a", 32'h1, {31'h0, ready_a});
        check_value("ready_b", 32'h1, {31'h0, ready_b});
        check_value("rdata_a", 32'h0, rdata_a);
        check_value("rdata_b", 32'h0, rdata_b);
        fork
            run_hart(1'b0);
            run_hart(1'b1);
        join
        $display("Checks %0d, value errors %0d, other errors %0d",
                 n_checks, n_value_err, n_other_err);
        if (n_value_err + n_other_err == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns with a hart still waiting for ready", TIMEOUT_NS);
        $display("Checks %0d, value errors %0d, other errors %0d",
                 n_checks, n_value_err, n_other_err);
        $display("TEST FAILED");
        $finish;
    end

endmodule : tb_shared_dmem
